// ==== source/sram_pkg.sv ====
// Shared constants and types for the APB memory subsystem.
// Every RTL file refers to these by scoped name, e.g. sram_pkg::data_t.
package sram_pkg;

    // data and bus widths
    localparam int DATA_W      = 32;
    localparam int STRB_W      = DATA_W / 8;   // one strobe per byte
    localparam int PADDR_W     = 10;           // APB byte address
    localparam int WORD_ADDR_W = PADDR_W - 2;  // drop byte offset

    // macro geometry, one fixed shape
    localparam int MACRO_W      = 16;
    localparam int MACRO_ROWS_W = 6;                          // 64 rows
    localparam int BANK_W       = WORD_ADDR_W - MACRO_ROWS_W; // upper bits pick bank
    localparam int BANKS        = 2 ** BANK_W;
    localparam int COLS         = DATA_W / MACRO_W;           // column slices per bank

    // bridge FSM encoding
    localparam int         ST_W       = 2;
    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_ACCESS  = 2'd1;
    localparam logic [1:0] ST_RD_WAIT = 2'd2;

    typedef logic [DATA_W-1:0] data_t;

    // word address, seen flat by the bridge and split by the wrapper
    typedef union packed {
        logic [WORD_ADDR_W-1:0] flat;
        struct packed {
            logic [BANK_W-1:0]       bank;
            logic [MACRO_ROWS_W-1:0] row;
        } fields;
    } word_addr_t;

endpackage

// ==== source/mem_if.sv ====
// One single-port memory cycle between the APB bridge and the SRAM wrapper.
// ce/we/wmask/addr/din are issued by the controller, dout returns a cycle later.
interface mem_if;

    logic                   ce;    // chip enable
    logic                   we;    // write enable, read when low
    sram_pkg::data_t        wmask; // per bit write mask
    sram_pkg::word_addr_t   addr;  // word address
    sram_pkg::data_t        din;   // write data
    sram_pkg::data_t        dout;  // read data, valid the cycle after a read

    // bridge side
    modport ctrl (
        output ce,
        output we,
        output wmask,
        output addr,
        output din,
        input  dout
    );

    // memory side
    modport ram (
        input  ce,
        input  we,
        input  wmask,
        input  addr,
        input  din,
        output dout
    );

endinterface

// ==== source/spram_macro.sv ====
// Behavioural model of a 64x16 single-port SRAM macro.
// Per-bit write mask, one cycle read latency, output holds between reads.
// Stands in for the hard macro in simulation and FPGA builds.
module spram_macro (
    input  logic                              clk,
    input  logic                              ce,    // chip enable
    input  logic                              we,    // write enable
    input  logic [sram_pkg::MACRO_W-1:0]      wmask, // per bit mask
    input  logic [sram_pkg::MACRO_ROWS_W-1:0] row,
    input  logic [sram_pkg::MACRO_W-1:0]      din,
    output logic [sram_pkg::MACRO_W-1:0]      dout
);

    localparam int ROWS = 2 ** sram_pkg::MACRO_ROWS_W;

    // bit cell array, contents undefined until written
    logic [sram_pkg::MACRO_W-1:0] ram [ROWS];

    logic [sram_pkg::MACRO_W-1:0] merged;

    // masked bits from din, the rest from the stored row
    assign merged = (ram[row] & ~wmask) | (din & wmask);

    // write port
    always_ff @(posedge clk) begin
        if (ce && we) begin
            ram[row] <= merged;
        end
    end

    // registered read port, holds value when not reading
    always_ff @(posedge clk) begin
        if (ce && !we) begin
            dout <= ram[row];
        end
    end

endmodule

// ==== source/spram_tiled.sv ====
// Word-addressed SRAM tiled from 64x16 macros.
// The upper address bits pick one of BANKS banks, each bank holds COLS column
// slices. Only the addressed bank is enabled; read data comes from the bank
// that was addressed when the read was issued.
module spram_tiled (
    input  logic clk,
    input  logic arst_n,
    mem_if.ram   mem
);

    sram_pkg::word_addr_t              addr;
    logic [sram_pkg::BANK_W-1:0]       bank;
    logic [sram_pkg::MACRO_ROWS_W-1:0] row;
    logic                              rd_issue;
    logic [sram_pkg::BANK_W-1:0]       rd_bank;   // bank of the last read

    // per bank output words, assembled from the column slices
    sram_pkg::data_t bank_dout [sram_pkg::BANKS];

    assign addr     = mem.addr;
    assign bank     = addr.fields.bank;
    assign row      = addr.fields.row;
    assign rd_issue = mem.ce && !mem.we;

    // remember which bank the macros are reading from
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_bank <= '0;
        end else if (rd_issue) begin
            rd_bank <= bank;
        end
    end

    for (genvar b = 0; b < sram_pkg::BANKS; b++) begin : g_bank
        logic sel;
        logic bank_ce;
        logic bank_we;

        assign sel     = (bank == b[sram_pkg::BANK_W-1:0]);
        assign bank_ce = mem.ce && sel;  // gate enables per bank
        assign bank_we = mem.we && sel;

        for (genvar c = 0; c < sram_pkg::COLS; c++) begin : g_col
            logic [sram_pkg::MACRO_W-1:0] col_din;
            logic [sram_pkg::MACRO_W-1:0] col_wmask;
            logic [sram_pkg::MACRO_W-1:0] col_dout;

            // column c holds bits c*MACRO_W and up
            assign col_din   = mem.din[c*sram_pkg::MACRO_W +: sram_pkg::MACRO_W];
            assign col_wmask = mem.wmask[c*sram_pkg::MACRO_W +: sram_pkg::MACRO_W];

            spram_macro u_macro (
                .clk   (clk),
                .ce    (bank_ce),
                .we    (bank_we),
                .wmask (col_wmask),
                .row   (row),
                .din   (col_din),
                .dout  (col_dout)
            );

            assign bank_dout[b][c*sram_pkg::MACRO_W +: sram_pkg::MACRO_W] = col_dout;
        end
    end

    // select the bank that was read, no OR across banks
    assign mem.dout = bank_dout[rd_bank];

endmodule

// ==== source/apb_sram_bridge.sv ====
// APB completer in front of the tiled SRAM.
// Writes complete in the first access cycle, aligned reads add one wait
// state for the macro latency, misaligned transfers end at once with pslverr.
module apb_sram_bridge (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [sram_pkg::PADDR_W-1:0] paddr,
    input  sram_pkg::data_t              pwdata,
    input  logic [sram_pkg::STRB_W-1:0]  pstrb,
    output sram_pkg::data_t              prdata,
    output logic                         pready,
    output logic                         pslverr,
    mem_if.ctrl                          mem
);

    logic [sram_pkg::ST_W-1:0] state;
    logic [sram_pkg::ST_W-1:0] state_nxt;

    logic                 access;     // first access cycle of a transfer
    logic                 misaligned; // byte offset bits set
    logic                 issue;      // memory cycle this cycle
    sram_pkg::word_addr_t waddr;
    sram_pkg::data_t      wmask;

    assign misaligned = (paddr[1:0] != 2'b00);
    assign access     = (state == sram_pkg::ST_ACCESS) && psel && penable;
    assign issue      = access && !misaligned;

    // FSM
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= sram_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            sram_pkg::ST_IDLE: begin
                if (psel && !penable) begin  // setup phase seen
                    state_nxt = sram_pkg::ST_ACCESS;
                end
            end
            sram_pkg::ST_ACCESS: begin
                if (issue && !pwrite) begin
                    state_nxt = sram_pkg::ST_RD_WAIT;  // wait for macro data
                end else if (access) begin
                    state_nxt = sram_pkg::ST_IDLE;
                end
            end
            sram_pkg::ST_RD_WAIT: begin
                state_nxt = sram_pkg::ST_IDLE;
            end
            default: begin
                state_nxt = sram_pkg::ST_IDLE;
            end
        endcase
    end

    // pstrb to bit mask, eight bits per byte
    always_comb begin
        for (int i = 0; i < sram_pkg::STRB_W; i++) begin
            wmask[8*i +: 8] = {8{pstrb[i]}};
        end
    end

    assign waddr.flat = paddr[sram_pkg::PADDR_W-1:2];  // word address

    // memory cycle, only for aligned transfers
    assign mem.ce    = issue;
    assign mem.we    = issue && pwrite;
    assign mem.wmask = wmask;
    assign mem.addr  = waddr;
    assign mem.din   = pwdata;

    // APB response
    assign pready  = psel && penable &&
                     ((access && (pwrite || misaligned)) ||
                      (state == sram_pkg::ST_RD_WAIT));
    assign pslverr = access && misaligned;
    assign prdata  = (state == sram_pkg::ST_RD_WAIT) ? mem.dout : '0;

endmodule

// ==== source/sram_apb_top.sv ====
// Top level of the APB memory subsystem.
// Plain APB ports outside, bridge and tiled SRAM joined by one mem_if.
module sram_apb_top (
    input  logic                         clk,
    input  logic                         arst_n,

    // APB completer port
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [sram_pkg::PADDR_W-1:0] paddr,
    input  sram_pkg::data_t              pwdata,
    input  logic [sram_pkg::STRB_W-1:0]  pstrb,
    output sram_pkg::data_t              prdata,
    output logic                         pready,
    output logic                         pslverr
);

    // memory cycle from bridge to wrapper
    mem_if mem0 ();

    apb_sram_bridge u_bridge (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .mem     (mem0.ctrl)
    );

    spram_tiled u_ram (
        .clk    (clk),
        .arst_n (arst_n),
        .mem    (mem0.ram)
    );

endmodule

// ==== bench/sram_apb_properties.sv ====
// Concurrent checks on the APB side of the bridge.
// Bound into every apb_sram_bridge instance.
module sram_apb_properties (
    input logic                         clk,
    input logic                         arst_n,
    input logic                         psel,
    input logic                         penable,
    input logic                         pwrite,
    input logic [sram_pkg::PADDR_W-1:0] paddr,
    input logic                         pready,
    input logic                         pslverr
);

    logic setup_q;       // previous cycle was a setup phase
    logic xfer_open;     // setup seen, pready not yet given
    logic first_access;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            setup_q   <= 1'b0;
            xfer_open <= 1'b0;
        end else begin
            setup_q <= psel && !penable;
            if (psel && !penable) begin
                xfer_open <= 1'b1;
            end else if (pready) begin
                xfer_open <= 1'b0;
            end
        end
    end

    assign first_access = psel && penable && setup_q;

    // error responses end the transfer in its first access cycle
    a_err_needs_ready: assert property (@(posedge clk) disable iff (!arst_n)
        pslverr |-> (pready && first_access))
        else $error("pslverr high without pready in the first access cycle");

    a_ready_in_access: assert property (@(posedge clk) disable iff (!arst_n)
        pready |-> (psel && penable && xfer_open))
        else $error("pready high outside an open access phase");

    // aligned read: one wait state, then pready
    a_read_wait: assert property (@(posedge clk) disable iff (!arst_n)
        (first_access && !pwrite && paddr[1:0] == 2'b00) |-> !pready ##1 pready)
        else $error("read pready not in the second access cycle");

endmodule

bind apb_sram_bridge sram_apb_properties u_props (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pready  (pready),
    .pslverr (pslverr)
);

// ==== bench/tb_sram_apb.sv ====
// Testbench for the APB memory subsystem.
// Runs the transfers listed in bench/sram_apb_cases.txt, then random writes
// and readbacks checked against a byte-masked model of the memory.
module tb_sram_apb;

    localparam int TIMEOUT  = 20;  // cycles to wait for pready
    localparam int N_RANDOM = 48;
    localparam int WORDS    = 2 ** sram_pkg::WORD_ADDR_W;

    logic                         clk;
    logic                         arst_n;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [sram_pkg::PADDR_W-1:0] paddr;
    sram_pkg::data_t              pwdata;
    logic [sram_pkg::STRB_W-1:0]  pstrb;
    sram_pkg::data_t              prdata;
    logic                         pready;
    logic                         pslverr;

    sram_pkg::data_t model [WORDS];    // expected memory contents
    logic            written [WORDS];  // word holds defined data
    integer          seed;
    int              n_cases;

    sram_apb_top dut0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_data(input string name, input sram_pkg::data_t expected,
                              input sram_pkg::data_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s prdata expected %h actual %h",
                                name, expected, actual));
        end
    endtask

    task automatic check_err(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s pslverr expected %b actual %b",
                                name, expected, actual));
        end
    endtask

    task automatic check_cycles(input string name, input int expected, input int actual);
        if (actual != expected) begin
            abort_run($sformatf("ERROR %s access cycles expected %0d actual %0d",
                                name, expected, actual));
        end
    endtask

    // one APB transfer, counts access cycles up to pready
    task automatic apb_transfer(input logic wr, input logic [sram_pkg::PADDR_W-1:0] addr,
                                input sram_pkg::data_t wdata,
                                input logic [sram_pkg::STRB_W-1:0] strb,
                                output sram_pkg::data_t rdata, output logic err,
                                output int cycles);
        bit done;
        @(posedge clk);
        psel    <= 1'b1;  // setup phase
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        pstrb   <= strb;
        @(posedge clk);
        penable <= 1'b1;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);  // outputs settled mid cycle
            cycles++;
            if (pready) begin
                rdata = prdata;
                err   = pslverr;
                done  = 1'b1;
            end else if (cycles >= TIMEOUT) begin
                abort_run($sformatf("pready never came for the transfer at paddr %h", addr));
            end
            @(posedge clk);
        end
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // run a transfer, check it and keep the model in step
    task automatic run_case(input string name, input logic wr,
                            input logic [sram_pkg::PADDR_W-1:0] addr,
                            input sram_pkg::data_t wdata,
                            input logic [sram_pkg::STRB_W-1:0] strb,
                            input sram_pkg::data_t exp_rdata, input logic exp_err);
        sram_pkg::data_t rdata;
        logic            err;
        int              cycles;
        int              exp_cycles;
        logic [7:0]      word;
        apb_transfer(wr, addr, wdata, strb, rdata, err, cycles);
        exp_cycles = (wr || addr[1:0] != 2'b00) ? 1 : 2;  // reads add one wait state
        check_err(name, exp_err, err);
        check_data(name, exp_rdata, rdata);
        check_cycles(name, exp_cycles, cycles);
        word = addr[sram_pkg::PADDR_W-1:2];
        if (wr && addr[1:0] == 2'b00) begin
            for (int b = 0; b < sram_pkg::STRB_W; b++) begin
                if (strb[b]) begin
                    model[word][8*b +: 8] = wdata[8*b +: 8];
                end
            end
            written[word] = 1'b1;
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        string       name;
        logic [31:0] f_write;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_strb;
        logic [31:0] f_rdata;
        logic [31:0] f_err;
        logic [31:0] rnd;
        logic [7:0]  waddr;
        logic [3:0]  wstrb;
        logic [7:0]  addr_q [$];
        seed    = 32'h5c88;
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        pstrb   = '0;
        n_cases = 0;
        for (int i = 0; i < WORDS; i++) begin
            written[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        fd = $fopen("bench/sram_apb_cases.txt", "r");
        if (fd == 0) begin
            abort_run("could not open bench/sram_apb_cases.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;  // blank or column notes
            end
            n = $sscanf(line, "%s %h %h %h %h %h %h", name, f_write, f_addr,
                        f_wdata, f_strb, f_rdata, f_err);
            if (n != 7) begin
                abort_run({"malformed line in case file: ", line});
            end
            run_case(name, f_write[0], f_addr[sram_pkg::PADDR_W-1:0], f_wdata,
                     f_strb[sram_pkg::STRB_W-1:0], f_rdata, f_err[0]);
            n_cases++;
        end
        $fclose(fd);

        // random writes, full strobe on first touch of a word
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd   = $random(seed);
            waddr = rnd[7:0];
            rnd   = $random(seed);
            wstrb = written[waddr] ? rnd[3:0] : 4'hf;
            run_case($sformatf("rand_wr_%0d", i), 1'b1, {waddr, 2'b00},
                     $random(seed), wstrb, '0, 1'b0);
            addr_q.push_back(waddr);
        end
        foreach (addr_q[i]) begin
            run_case($sformatf("rand_rd_%0d", i), 1'b0, {addr_q[i], 2'b00}, '0, '0,
                     model[addr_q[i]], 1'b0);
        end

        if (n_cases == 0) begin
            abort_run("no cases were read from the case file");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// ==== bench/sram_apb_cases.txt ====
# columns: name pwrite paddr pwdata pstrb exp_prdata exp_pslverr
# all numbers hex, paddr is the APB byte address
# write then read back in every bank
wr_bank0 1 004 a5a51234 f 00000000 0
wr_bank1 1 108 5a5a8765 f 00000000 0
wr_bank2 1 2f0 deadbeef f 00000000 0
wr_bank3 1 3fc 0badf00d f 00000000 0
rd_bank0 0 004 00000000 0 a5a51234 0
rd_bank1 0 108 00000000 0 5a5a8765 0
rd_bank2 0 2f0 00000000 0 deadbeef 0
rd_bank3 0 3fc 00000000 0 0badf00d 0
# byte strobes
wr_full 1 040 11223344 f 00000000 0
wr_strb5 1 040 aabbccdd 5 00000000 0
rd_strb5 0 040 00000000 0 11bb33dd 0
wr_strba 1 040 99887766 a 00000000 0
rd_strba 0 040 00000000 0 99bb77dd 0
# bank isolation, row 0x20 in all four banks
iso_wr0 1 080 10101010 f 00000000 0
iso_wr1 1 180 20202020 f 00000000 0
iso_wr2 1 280 30303030 f 00000000 0
iso_wr3 1 380 40404040 f 00000000 0
iso_rd3 0 380 00000000 0 40404040 0
iso_rd0 0 080 00000000 0 10101010 0
iso_rd2 0 280 00000000 0 30303030 0
iso_rd1 0 180 00000000 0 20202020 0
# misaligned transfers leave memory untouched
mis_rd 0 081 00000000 0 00000000 1
mis_wr 1 082 ffffffff f 00000000 1
mis_chk 0 080 00000000 0 10101010 0
mis_wr3 1 3ff 12345678 f 00000000 1
mis_chk3 0 3fc 00000000 0 0badf00d 0

// ==== all.f ====
source/sram_pkg.sv
source/mem_if.sv
source/spram_macro.sv
source/spram_tiled.sv
source/apb_sram_bridge.sv
source/sram_apb_top.sv
bench/sram_apb_properties.sv
bench/tb_sram_apb.sv

// ==== Bender.yml ====
package:
  name: sram_apb

sources:
  # RTL in compile order
  - files:
      - source/sram_pkg.sv
      - source/mem_if.sv
      - source/spram_macro.sv
      - source/spram_tiled.sv
      - source/apb_sram_bridge.sv
      - source/sram_apb_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - bench/sram_apb_properties.sv
      - bench/tb_sram_apb.sv
